/* exec_cluster.f */
+incdir+sim
verilog/exec_pkg.sv
verilog/alu_core.sv
verilog/alu_pipe.sv
verilog/prf.sv
verilog/exec_cluster.sv
sim/tb_exec_cluster.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f exec_cluster.f \
    --top-module tb_exec_cluster \
    -o sim_exec_cluster

out=$(./obj_dir/sim_exec_cluster)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* sim/tb_stim.svh */
// directed issue pairs, one row per cycle
// each row is make_slot(valid, op, rd, rs, rt, imm) for iss0, then for iss1
task automatic load_directed_rows();
    // unwritten registers read zero
    add_pair(make_slot(1, OP_ADD,   1,  0,  0, 'h0000),
             make_slot(1, OP_ADD,   2,  5,  6, 'h0000));
    // immediate forms on both pipes
    add_pair(make_slot(1, OP_LI,    1,  0,  0, 'h1234),
             make_slot(1, OP_LI,    2,  0,  0, 'h8001));
    add_pair(make_slot(1, OP_ADDI,  3,  0,  0, 'h7fff),
             make_slot(1, OP_ADDI,  4,  0,  0, 'h8000));
    add_pair(make_slot(1, OP_ADDI,  5,  0,  0, 'hfff0),
             make_slot(1, OP_LI,    6,  0,  0, 'h00ff));
    add_pair(make_slot(1, OP_ADDI,  7,  1,  0, 'h0042),
             make_slot(1, OP_ADDI,  8,  2,  0, 'hffff));
    // back to back chains, each pipe feeds itself
    add_pair(make_slot(1, OP_ADDI, 10,  0,  0, 'h0005),
             make_slot(1, OP_ADDI, 20,  0,  0, 'h0003));
    add_pair(make_slot(1, OP_ADD,  11, 10,  3, 'h0000),
             make_slot(1, OP_SUB,  21, 20,  4, 'h0000));
    add_pair(make_slot(1, OP_SUB,  12, 11, 10, 'h0000),
             make_slot(1, OP_AND,  22, 21,  3, 'h0000));
    add_pair(make_slot(1, OP_AND,  13, 12,  3, 'h0000),
             make_slot(1, OP_OR,   23, 22,  1, 'h0000));
    add_pair(make_slot(1, OP_OR,   14, 13,  2, 'h0000),
             make_slot(1, OP_XOR,  24, 23,  4, 'h0000));
    // r4 and r5 hold negative values
    add_pair(make_slot(1, OP_XOR,  15, 14,  4, 'h0000),
             make_slot(1, OP_SLT,  25,  4, 24, 'h0000));
    add_pair(make_slot(1, OP_SLT,  16, 15,  5, 'h0000),
             make_slot(1, OP_SLL,  26, 24, 25, 'h0000));
    add_pair(make_slot(1, OP_SLL,  17, 10, 16, 'h0000),
             make_slot(1, OP_SLT,  27, 26,  4, 'h0000));
    add_pair(make_slot(1, OP_SLT,  18,  5, 17, 'h0000),
             make_slot(1, OP_ADD,  28, 27, 27, 'h0000));
    add_pair(make_slot(1, OP_SLL,  19, 18, 10, 'h0000),
             make_slot(0, OP_ADD,   0,  0,  0, 'h0000));
    // cross-pipe dependence one cycle apart
    add_pair(make_slot(1, OP_LI,   30,  0,  0, 'hcafe),
             make_slot(1, OP_ADDI, 31,  0,  0, 'h0011));
    add_pair(make_slot(1, OP_ADD,  32, 31, 31, 'h0000),
             make_slot(1, OP_SUB,  33, 30,  3, 'h0000));
    add_pair(make_slot(1, OP_XOR,  34, 33, 32, 'h0000),
             make_slot(1, OP_ADD,  35, 32, 33, 'h0000));
    add_pair(make_slot(0, OP_ADD,   0,  0,  0, 'h0000),
             make_slot(1, OP_OR,   36, 34, 35, 'h0000));
    // same-edge pair, iss1 still reads the older r40
    add_pair(make_slot(1, OP_LI,   40,  0,  0, 'h0abc),
             make_slot(0, OP_ADD,   0,  0,  0, 'h0000));
    add_pair(make_slot(0, OP_ADD,   0,  0,  0, 'h0000),
             make_slot(0, OP_ADD,   0,  0,  0, 'h0000));
    add_pair(make_slot(1, OP_LI,   40,  0,  0, 'h5555),
             make_slot(1, OP_ADD,  41, 40,  0, 'h0000));
    add_pair(make_slot(0, OP_ADD,   0,  0,  0, 'h0000),
             make_slot(0, OP_ADD,   0,  0,  0, 'h0000));
    // stored values, read well after the write
    add_pair(make_slot(1, OP_ADD,  42, 40,  0, 'h0000),
             make_slot(1, OP_ADDI, 43, 40,  0, 'h0001));
    add_pair(make_slot(1, OP_SLL,  44,  1, 20, 'h0000),
             make_slot(1, OP_SUB,  45,  0,  1, 'h0000));
    add_pair(make_slot(1, OP_SLT,  46, 45,  0, 'h0000),
             make_slot(1, OP_SLT,  47,  0, 45, 'h0000));
endtask

/* sim/tb_exec_cluster.sv */
`timescale 1ns/1ps

module tb_exec_cluster import exec_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 5;
    localparam int RAND_ROWS  = 40;
    localparam int RAND_SEED  = 12638;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        prf_num_t         rd;
        prf_num_t         rs;
        prf_num_t         rt;
        logic [IMM_W-1:0] imm;
    } slot_t;

    typedef struct packed {
        slot_t p0;
        slot_t p1;
    } pair_t;

    typedef struct packed {
        logic              valid;
        prf_num_t          rd;
        logic [DATA_W-1:0] data;
    } wb_exp_t;

    logic              aclk;
    logic              arst_n_i;
    logic              iss0_valid_i;
    alu_op_e           iss0_op_i;
    prf_num_t          iss0_rd_i;
    prf_num_t          iss0_rs_i;
    prf_num_t          iss0_rt_i;
    logic [IMM_W-1:0]  iss0_imm_i;
    logic              iss1_valid_i;
    alu_op_e           iss1_op_i;
    prf_num_t          iss1_rd_i;
    prf_num_t          iss1_rs_i;
    prf_num_t          iss1_rt_i;
    logic [IMM_W-1:0]  iss1_imm_i;
    logic              wb0_valid_o;
    prf_num_t          wb0_rd_o;
    logic [DATA_W-1:0] wb0_data_o;
    logic              wb1_valid_o;
    prf_num_t          wb1_rd_o;
    logic [DATA_W-1:0] wb1_data_o;

    pair_t             stim_q [$];
    wb_exp_t           exp0_q [$];
    wb_exp_t           exp1_q [$];
    logic [DATA_W-1:0] model_regs [PRF_DEPTH];
    int                mismatch_errors;
    int                other_errors;
    logic              table_ready;

    exec_cluster exec_cluster_inst (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .iss0_valid_i (iss0_valid_i),
        .iss0_op_i    (iss0_op_i),
        .iss0_rd_i    (iss0_rd_i),
        .iss0_rs_i    (iss0_rs_i),
        .iss0_rt_i    (iss0_rt_i),
        .iss0_imm_i   (iss0_imm_i),
        .iss1_valid_i (iss1_valid_i),
        .iss1_op_i    (iss1_op_i),
        .iss1_rd_i    (iss1_rd_i),
        .iss1_rs_i    (iss1_rs_i),
        .iss1_rt_i    (iss1_rt_i),
        .iss1_imm_i   (iss1_imm_i),
        .wb0_valid_o  (wb0_valid_o),
        .wb0_rd_o     (wb0_rd_o),
        .wb0_data_o   (wb0_data_o),
        .wb1_valid_o  (wb1_valid_o),
        .wb1_rd_o     (wb1_rd_o),
        .wb1_data_o   (wb1_data_o)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic slot_t make_slot(
        input int      v,
        input alu_op_e op,
        input int      rd,
        input int      rs,
        input int      rt,
        input int      imm
    );
        slot_t s;
        s.valid = (v != 0);
        s.op    = op;
        s.rd    = rd[PRF_AW-1:0];
        s.rs    = rs[PRF_AW-1:0];
        s.rt    = rt[PRF_AW-1:0];
        s.imm   = imm[IMM_W-1:0];
        return s;
    endfunction

    task automatic add_pair(input slot_t s0, input slot_t s1);
        pair_t p;
        p.p0 = s0;
        p.p1 = s1;
        stim_q.push_back(p);
    endtask

    // pipe 0 writes r32..r47 and pipe 1 writes r48..r63 so writes never collide
    task automatic add_random_rows(input int count);
        alu_op_e ops [9];
        int      imm_a;
        int      imm_b;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_ADDI, OP_LI};
        for (int i = 0; i < count; i++) begin
            imm_a = $urandom % 65536;
            imm_b = $urandom % 65536;
            add_pair(make_slot(1, ops[i % 9], 32 + i % 16, (i * 7 + 1) % 64,
                               (i * 5 + 33) % 64, imm_a),
                     make_slot(1, ops[(i * 4 + 3) % 9], 48 + (i * 3) % 16,
                               (i * 11 + 2) % 64, (i * 13 + 40) % 64, imm_b));
        end
    endtask

    `include "tb_stim.svh"

    function automatic logic [DATA_W-1:0] ref_result(
        input alu_op_e           op,
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b,
        input logic [IMM_W-1:0]  imm
    );
        logic [DATA_W-1:0]        value;
        logic signed [DATA_W-1:0] imm_val;
        value   = '0;
        imm_val = $signed(imm);
        case (op)
            OP_ADD:  value = a + b;
            OP_SUB:  value = a - b;
            OP_AND:  value = a & b;
            OP_OR:   value = a | b;
            OP_XOR:  value = a ^ b;
            OP_SLT: begin
                // with differing signs the negative one is smaller
                if (a[DATA_W-1] != b[DATA_W-1]) begin
                    value[0] = a[DATA_W-1];
                end else begin
                    value[0] = (a < b);
                end
            end
            OP_SLL:  value = a << b[4:0];
            OP_ADDI: value = a + imm_val;
            OP_LI:   value = DATA_W'(imm) << 16;
            default: value = '0;
        endcase
        return value;
    endfunction

    // both items of a row see the register values from before the row
    task automatic model_row(input pair_t pair);
        logic [DATA_W-1:0] res0;
        logic [DATA_W-1:0] res1;
        wb_exp_t           e0;
        wb_exp_t           e1;
        res0 = ref_result(pair.p0.op, model_regs[pair.p0.rs], model_regs[pair.p0.rt],
                          pair.p0.imm);
        res1 = ref_result(pair.p1.op, model_regs[pair.p1.rs], model_regs[pair.p1.rt],
                          pair.p1.imm);
        if (pair.p0.valid) begin
            model_regs[pair.p0.rd] = res0;
        end
        if (pair.p1.valid) begin
            model_regs[pair.p1.rd] = res1;
        end
        e0.valid = pair.p0.valid;
        e0.rd    = pair.p0.rd;
        e0.data  = res0;
        e1.valid = pair.p1.valid;
        e1.rd    = pair.p1.rd;
        e1.data  = res1;
        exp0_q.push_back(e0);
        exp1_q.push_back(e1);
    endtask

    task automatic drive_pair(input pair_t pair);
        iss0_valid_i = pair.p0.valid;
        iss0_op_i    = pair.p0.op;
        iss0_rd_i    = pair.p0.rd;
        iss0_rs_i    = pair.p0.rs;
        iss0_rt_i    = pair.p0.rt;
        iss0_imm_i   = pair.p0.imm;
        iss1_valid_i = pair.p1.valid;
        iss1_op_i    = pair.p1.op;
        iss1_rd_i    = pair.p1.rd;
        iss1_rs_i    = pair.p1.rs;
        iss1_rt_i    = pair.p1.rt;
        iss1_imm_i   = pair.p1.imm;
    endtask

    task automatic compare_port(
        input int                port,
        input wb_exp_t           want,
        input logic              act_valid,
        input prf_num_t          act_rd,
        input logic [DATA_W-1:0] act_data
    );
        if (want.valid && act_valid !== 1'b1) begin
            $display("at %0t: wb%0d missed the writeback to r%0d, valid is low",
                     $time, port, want.rd);
            other_errors++;
        end else if (!want.valid && act_valid !== 1'b0) begin
            $display("at %0t: wb%0d raised valid with nothing issued", $time, port);
            other_errors++;
        end else if (want.valid) begin
            if (act_rd !== want.rd) begin
                $display("MISMATCH at %0t: wb%0d_rd_o expected %0d, actual %0d",
                         $time, port, want.rd, act_rd);
                mismatch_errors++;
            end
            if (act_data !== want.data) begin
                $display("MISMATCH at %0t: wb%0d_data_o expected %08h, actual %08h",
                         $time, port, want.data, act_data);
                mismatch_errors++;
            end
        end
    endtask

    initial begin
        pair_t   pair;
        pair_t   idle_pair;
        wb_exp_t idle_exp;
        int      n_rows;
        arst_n_i    = 1'b0;
        table_ready = 1'b0;
        idle_pair   = '0;
        idle_exp    = '0;
        drive_pair(idle_pair);
        mismatch_errors = 0;
        other_errors    = 0;
        for (int r = 0; r < PRF_DEPTH; r++) begin
            model_regs[r] = '0;
        end
        void'($urandom(RAND_SEED));
        load_directed_rows();
        add_random_rows(RAND_ROWS);
        n_rows      = stim_q.size();
        table_ready = 1'b1;

        repeat (RST_CYCLES) begin
            @(posedge aclk);
            #1;
            if (wb0_valid_o !== 1'b0 || wb1_valid_o !== 1'b0) begin
                $display("at %0t: a wb valid output is high during reset", $time);
                other_errors++;
            end
        end
        arst_n_i = 1'b1;

        // nothing is in flight for the first two checks after reset
        exp0_q.push_back(idle_exp);
        exp0_q.push_back(idle_exp);
        exp1_q.push_back(idle_exp);
        exp1_q.push_back(idle_exp);

        for (int i = 0; i < n_rows + 2; i++) begin
            @(posedge aclk);
            #1;
            compare_port(0, exp0_q.pop_front(), wb0_valid_o, wb0_rd_o, wb0_data_o);
            compare_port(1, exp1_q.pop_front(), wb1_valid_o, wb1_rd_o, wb1_data_o);
            if (i < n_rows) begin
                pair = stim_q[i];
            end else begin
                pair = idle_pair;
            end
            model_row(pair);
            drive_pair(pair);
        end

        $display("checks done: %0d mismatches, %0d other errors",
                 mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready === 1'b1);
        #((RST_CYCLES + stim_q.size() + 10) * CLK_PERIOD);
        $display("timeout: the stimulus table did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* verilog/alu_core.sv */
`timescale 1ns/1ps

module alu_core import exec_pkg::*; (
    input  alu_op_e           op_i,
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    input  logic [IMM_W-1:0]  imm_i,
    output logic [DATA_W-1:0] result_o
);

    logic [DATA_W-1:0]  imm_sext;
    logic [DATA_W-1:0]  imm_high;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;

    assign imm_sext  = {{(DATA_W-IMM_W){imm_i[IMM_W-1]}}, imm_i};
    assign imm_high  = {imm_i, {(DATA_W-IMM_W){1'b0}}};
    assign shamt     = b_i[SHAMT_W-1:0];
    assign lt_signed = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = a_i + b_i;
            end
            OP_SUB: begin
                result_o = a_i - b_i;
            end
            OP_AND: begin
                result_o = a_i & b_i;
            end
            OP_OR: begin
                result_o = a_i | b_i;
            end
            OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            OP_SLT: begin
                result_o = {{(DATA_W-1){1'b0}}, lt_signed};
            end
            OP_SLL: begin
                result_o = a_i << shamt;
            end
            OP_ADDI: begin
                result_o = a_i + imm_sext;
            end
            OP_LI: begin
                // rs is ignored here
                result_o = imm_high;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* verilog/alu_pipe.sv */
`timescale 1ns/1ps

module alu_pipe import exec_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n_i,

    // issue
    input  logic              valid_i,
    input  alu_op_e           op_i,
    input  prf_num_t          rd_i,
    input  prf_num_t          rs_i,
    input  prf_num_t          rt_i,
    input  logic [IMM_W-1:0]  imm_i,

    // register file read
    output prf_num_t          rs_addr_o,
    output prf_num_t          rt_addr_o,
    input  logic [DATA_W-1:0] rs_data_i,
    input  logic [DATA_W-1:0] rt_data_i,

    // bypass from both writeback registers
    input  logic              fwd_a_valid_i,
    input  prf_num_t          fwd_a_rd_i,
    input  logic [DATA_W-1:0] fwd_a_data_i,
    input  logic              fwd_b_valid_i,
    input  prf_num_t          fwd_b_rd_i,
    input  logic [DATA_W-1:0] fwd_b_data_i,

    // writeback
    output logic              wb_valid_o,
    output prf_num_t          wb_rd_o,
    output logic [DATA_W-1:0] wb_data_o
);

    // read stage
    logic              rs_valid_q;
    alu_op_e           rs_op_q;
    prf_num_t          rs_rd_q;
    prf_num_t          rs_src_q;
    prf_num_t          rt_src_q;
    logic [IMM_W-1:0]  rs_imm_q;

    logic [DATA_W-1:0] opnd_a;
    logic [DATA_W-1:0] opnd_b;
    logic [DATA_W-1:0] alu_result;

    // writeback stage
    logic              wb_valid_q;
    prf_num_t          wb_rd_q;
    logic [DATA_W-1:0] wb_data_q;

    // bypass beats the register file, pipe a wins a tie
    function automatic logic [DATA_W-1:0] pick_operand(
        input prf_num_t          src,
        input logic [DATA_W-1:0] prf_data
    );
        logic [DATA_W-1:0] value;
        value = prf_data;
        if (fwd_b_valid_i && (fwd_b_rd_i == src)) begin
            value = fwd_b_data_i;
        end
        if (fwd_a_valid_i && (fwd_a_rd_i == src)) begin
            value = fwd_a_data_i;
        end
        return value;
    endfunction

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rs_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            rs_valid_q <= valid_i;
            wb_valid_q <= rs_valid_q;
        end
    end

    always_ff @(posedge aclk) begin
        rs_op_q   <= op_i;
        rs_rd_q   <= rd_i;
        rs_src_q  <= rs_i;
        rt_src_q  <= rt_i;
        rs_imm_q  <= imm_i;
        wb_rd_q   <= rs_rd_q;
        wb_data_q <= alu_result;
    end

    assign rs_addr_o = rs_src_q;
    assign rt_addr_o = rt_src_q;

    always_comb begin
        opnd_a = pick_operand(rs_src_q, rs_data_i);
        opnd_b = pick_operand(rt_src_q, rt_data_i);
    end

    alu_core u_alu (
        .op_i     (rs_op_q),
        .a_i      (opnd_a),
        .b_i      (opnd_b),
        .imm_i    (rs_imm_q),
        .result_o (alu_result)
    );

    assign wb_valid_o = wb_valid_q;
    assign wb_rd_o    = wb_rd_q;
    assign wb_data_o  = wb_data_q;

    // an issued item must carry a known opcode
    a_op_defined: assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        rs_valid_q |-> (rs_op_q inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                        OP_SLT, OP_SLL, OP_ADDI, OP_LI})
    ) else $error("alu_pipe: undefined opcode %0h in read stage", rs_op_q);

endmodule

/* verilog/exec_cluster.sv */
`timescale 1ns/1ps

module exec_cluster import exec_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n_i,

    // issue port 0
    input  logic              iss0_valid_i,
    input  alu_op_e           iss0_op_i,
    input  prf_num_t          iss0_rd_i,
    input  prf_num_t          iss0_rs_i,
    input  prf_num_t          iss0_rt_i,
    input  logic [IMM_W-1:0]  iss0_imm_i,

    // issue port 1
    input  logic              iss1_valid_i,
    input  alu_op_e           iss1_op_i,
    input  prf_num_t          iss1_rd_i,
    input  prf_num_t          iss1_rs_i,
    input  prf_num_t          iss1_rt_i,
    input  logic [IMM_W-1:0]  iss1_imm_i,

    // writeback
    output logic              wb0_valid_o,
    output prf_num_t          wb0_rd_o,
    output logic [DATA_W-1:0] wb0_data_o,
    output logic              wb1_valid_o,
    output prf_num_t          wb1_rd_o,
    output logic [DATA_W-1:0] wb1_data_o
);

    prf_num_t          p0_rs_addr;
    prf_num_t          p0_rt_addr;
    prf_num_t          p1_rs_addr;
    prf_num_t          p1_rt_addr;
    logic [DATA_W-1:0] p0_rs_data;
    logic [DATA_W-1:0] p0_rt_data;
    logic [DATA_W-1:0] p1_rs_data;
    logic [DATA_W-1:0] p1_rt_data;

    // both pipes see both writeback registers as bypass
    alu_pipe u_pipe0 (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (iss0_valid_i),
        .op_i          (iss0_op_i),
        .rd_i          (iss0_rd_i),
        .rs_i          (iss0_rs_i),
        .rt_i          (iss0_rt_i),
        .imm_i         (iss0_imm_i),
        .rs_addr_o     (p0_rs_addr),
        .rt_addr_o     (p0_rt_addr),
        .rs_data_i     (p0_rs_data),
        .rt_data_i     (p0_rt_data),
        .fwd_a_valid_i (wb0_valid_o),
        .fwd_a_rd_i    (wb0_rd_o),
        .fwd_a_data_i  (wb0_data_o),
        .fwd_b_valid_i (wb1_valid_o),
        .fwd_b_rd_i    (wb1_rd_o),
        .fwd_b_data_i  (wb1_data_o),
        .wb_valid_o    (wb0_valid_o),
        .wb_rd_o       (wb0_rd_o),
        .wb_data_o     (wb0_data_o)
    );

    alu_pipe u_pipe1 (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (iss1_valid_i),
        .op_i          (iss1_op_i),
        .rd_i          (iss1_rd_i),
        .rs_i          (iss1_rs_i),
        .rt_i          (iss1_rt_i),
        .imm_i         (iss1_imm_i),
        .rs_addr_o     (p1_rs_addr),
        .rt_addr_o     (p1_rt_addr),
        .rs_data_i     (p1_rs_data),
        .rt_data_i     (p1_rt_data),
        .fwd_a_valid_i (wb0_valid_o),
        .fwd_a_rd_i    (wb0_rd_o),
        .fwd_a_data_i  (wb0_data_o),
        .fwd_b_valid_i (wb1_valid_o),
        .fwd_b_rd_i    (wb1_rd_o),
        .fwd_b_data_i  (wb1_data_o),
        .wb_valid_o    (wb1_valid_o),
        .wb_rd_o       (wb1_rd_o),
        .wb_data_o     (wb1_data_o)
    );

    prf u_prf (
        .aclk      (aclk),
        .arst_n_i  (arst_n_i),
        .r0_addr_i (p0_rs_addr),
        .r1_addr_i (p0_rt_addr),
        .r2_addr_i (p1_rs_addr),
        .r3_addr_i (p1_rt_addr),
        .r0_data_o (p0_rs_data),
        .r1_data_o (p0_rt_data),
        .r2_data_o (p1_rs_data),
        .r3_data_o (p1_rt_data),
        .w0_en_i   (wb0_valid_o),
        .w0_addr_i (wb0_rd_o),
        .w0_data_i (wb0_data_o),
        .w1_en_i   (wb1_valid_o),
        .w1_addr_i (wb1_rd_o),
        .w1_data_i (wb1_data_o)
    );

endmodule

/* verilog/exec_pkg.sv */
package exec_pkg;

    // datapath
    localparam int DATA_W    = 32;
    localparam int IMM_W     = 16;

    // shift amount comes from the low bits of the second operand
    localparam int SHAMT_W   = 5;

    // physical register file
    localparam int PRF_DEPTH = 64;
    localparam int PRF_AW    = 6;

    // opcode field width
    localparam int OP_W      = 4;

    typedef logic [PRF_AW-1:0] prf_num_t;

    typedef enum logic [OP_W-1:0] {
        // register with register
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,

        // signed compare, writes 1 or 0
        OP_SLT  = 4'h5,

        // shift by rt[4:0]
        OP_SLL  = 4'h6,

        // rs plus sign-extended immediate
        OP_ADDI = 4'h7,

        // immediate into the upper half
        OP_LI   = 4'h8
    } alu_op_e;

endpackage

/* verilog/prf.sv */
`timescale 1ns/1ps

module prf import exec_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n_i,

    // read ports, two per pipe
    input  prf_num_t          r0_addr_i,
    input  prf_num_t          r1_addr_i,
    input  prf_num_t          r2_addr_i,
    input  prf_num_t          r3_addr_i,
    output logic [DATA_W-1:0] r0_data_o,
    output logic [DATA_W-1:0] r1_data_o,
    output logic [DATA_W-1:0] r2_data_o,
    output logic [DATA_W-1:0] r3_data_o,

    // write ports from the two writeback registers
    input  logic              w0_en_i,
    input  prf_num_t          w0_addr_i,
    input  logic [DATA_W-1:0] w0_data_i,
    input  logic              w1_en_i,
    input  prf_num_t          w1_addr_i,
    input  logic [DATA_W-1:0] w1_data_i
);

    logic [DATA_W-1:0] regs_q [PRF_DEPTH];

    // all registers read zero out of reset
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PRF_DEPTH; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (w0_en_i) begin
                regs_q[w0_addr_i] <= w0_data_i;
            end
            if (w1_en_i) begin
                regs_q[w1_addr_i] <= w1_data_i;
            end
        end
    end

    // combinational reads, no internal bypass
    assign r0_data_o = regs_q[r0_addr_i];
    assign r1_data_o = regs_q[r1_addr_i];
    assign r2_data_o = regs_q[r2_addr_i];
    assign r3_data_o = regs_q[r3_addr_i];

    // the two pipes never target one register in the same cycle
    a_no_dual_write: assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        (w0_en_i && w1_en_i) |-> (w0_addr_i != w1_addr_i)
    ) else $error("prf: both write ports target register %0d", w0_addr_i);

endmodule
